//--- verilog/ttc_reg_pkg.sv
//--------------------
// Register map of the triple-compare timer
// Holds the APB widths, the register offsets and the layout of the
// interrupt register. Imported by the register file, the interrupt
// block and the top level.
//--------------------
`default_nettype none

package ttc_reg_pkg;

  //--------------------
  // Bus widths
  //--------------------
  localparam int addr_w = 8;            // Byte address
  localparam int data_w = 32;

  //--------------------
  // Register offsets
  //--------------------
  localparam logic [addr_w-1:0] addr_ctrl     = 8'h00; // Enable, mode, match_en, restart
  localparam logic [addr_w-1:0] addr_interval = 8'h04;
  localparam logic [addr_w-1:0] addr_match1   = 8'h08;
  localparam logic [addr_w-1:0] addr_match2   = 8'h0C;
  localparam logic [addr_w-1:0] addr_match3   = 8'h10;
  localparam logic [addr_w-1:0] addr_count    = 8'h14; // Read only, live value
  localparam logic [addr_w-1:0] addr_intr     = 8'h18; // Cleared by a read
  localparam logic [addr_w-1:0] addr_intr_en  = 8'h1C;

  //--------------------
  // Interrupt register
  //--------------------
  localparam int intr_w = 6;

  // Same layout for status, enable and write data
  typedef struct packed {
    logic spare;                        // Bit 5, never set
    logic overflow;                     // Bit 4, free-run wrap
    logic match3;
    logic match2;
    logic match1;
    logic interval;                     // Bit 0, interval wrap
  } ttc_intr_bits_t;

endpackage

`default_nettype wire

//--- verilog/ttc_cnt_pkg.sv
//--------------------
// Counter types of the triple-compare timer
// Count width, control bits, compare values and event pulses
// shared by the register file, the counter and the interrupt block
//--------------------
`default_nettype none

package ttc_cnt_pkg;

  localparam int cnt_w = 16;
  localparam logic [cnt_w-1:0] cnt_max = {cnt_w{1'b1}}; // Free-run wrap point

  typedef logic [cnt_w-1:0] ttc_count_t;

  // Control register bits 2..0, first field is the top bit
  typedef struct packed {
    logic match_en;                     // Bit 2
    logic interval_mode;                // Bit 1, else free-run
    logic enable;                       // Bit 0
  } ttc_ctrl_t;

  localparam int ctrl_w      = $bits(ttc_ctrl_t);
  localparam int restart_bit = 3;       // Write-one pulse, not stored

  // Values the count is compared against
  typedef struct packed {
    ttc_count_t interval;
    ttc_count_t match1;
    ttc_count_t match2;
    ttc_count_t match3;
  } ttc_cmp_t;

  // One-cycle pulses from the counter
  typedef struct packed {
    logic       overflow;
    logic [2:0] match;                  // [2] match3 down to [0] match1
    logic       interval;
  } ttc_events_t;

endpackage

`default_nettype wire

//--- verilog/ttc_apb_regs.sv
//--------------------
// APB register file of the timer
// Decodes zero-wait APB accesses, holds control, interval and match
// values, muxes read data and makes the restart and clear strobes.
// The interrupt enable register itself sits in the interrupt block.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module ttc_apb_regs
  import ttc_reg_pkg::*;
  import ttc_cnt_pkg::*;
(
  input  wire logic              pclk7,
  input  wire logic              n_p_reset7,
  input  wire logic              psel,
  input  wire logic              penable,
  input  wire logic              pwrite,
  input  wire logic [addr_w-1:0] paddr,
  input  wire logic [data_w-1:0] pwdata,
  input  wire ttc_count_t        count,       // Live count
  input  wire ttc_intr_bits_t    intr_reg,
  input  wire ttc_intr_bits_t    intr_en,
  output logic      [data_w-1:0] prdata,
  output ttc_ctrl_t              ctrl,
  output ttc_cmp_t               cmp,
  output logic                   restart,     // One cycle after the write
  output logic                   intr_en_sel,
  output logic                   clear_interrupt,
  output ttc_intr_bits_t         wdata_en
);

  logic      wr_access;                 // Access phase of a write
  logic      rd_access;                 // Access phase of a read
  ttc_ctrl_t ctrl_q;
  ttc_cmp_t  cmp_q;
  logic      restart_q;

  assign wr_access = psel & penable & pwrite;
  assign rd_access = psel & penable & ~pwrite;

  //--------------------
  // Strobes to the interrupt block
  //--------------------
  assign intr_en_sel     = wr_access && (paddr == addr_intr_en);
  assign clear_interrupt = rd_access && (paddr == addr_intr);   // Clear on read
  assign wdata_en        = ttc_intr_bits_t'(pwdata[intr_w-1:0]);

  //--------------------
  // Write registers
  //--------------------
  always_ff @(posedge pclk7 or negedge n_p_reset7)
  begin
    if (!n_p_reset7)
    begin
      ctrl_q    <= '0;
      cmp_q     <= '0;
      restart_q <= 1'b0;
    end
    else
    begin
      restart_q <= 1'b0;                // Pulse, low unless written
      if (wr_access)
      begin
        case (paddr)
          addr_ctrl:
          begin
            ctrl_q    <= ttc_ctrl_t'(pwdata[ctrl_w-1:0]);
            restart_q <= pwdata[restart_bit];
          end
          addr_interval: cmp_q.interval <= pwdata[cnt_w-1:0];
          addr_match1:   cmp_q.match1   <= pwdata[cnt_w-1:0];
          addr_match2:   cmp_q.match2   <= pwdata[cnt_w-1:0];
          addr_match3:   cmp_q.match3   <= pwdata[cnt_w-1:0];
          default:       ;              // Read only or undecoded
        endcase
      end
    end
  end

  assign ctrl    = ctrl_q;
  assign cmp     = cmp_q;
  assign restart = restart_q;

  //--------------------
  // Read mux, zero outside a read access
  //--------------------
  always_comb
  begin
    prdata = '0;
    if (rd_access)
    begin
      case (paddr)
        addr_ctrl:     prdata[ctrl_w-1:0] = ctrl_q;  // Restart bit reads zero
        addr_interval: prdata[cnt_w-1:0]  = cmp_q.interval;
        addr_match1:   prdata[cnt_w-1:0]  = cmp_q.match1;
        addr_match2:   prdata[cnt_w-1:0]  = cmp_q.match2;
        addr_match3:   prdata[cnt_w-1:0]  = cmp_q.match3;
        addr_count:    prdata[cnt_w-1:0]  = count;
        addr_intr:     prdata[intr_w-1:0] = intr_reg;
        addr_intr_en:  prdata[intr_w-1:0] = intr_en;
        default:       prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/ttc_counter.sv
//--------------------
// 16-bit up counter of the timer
// Counts while enabled, wraps at the interval value or at 0xFFFF
// depending on mode, and compares against three match values.
// Event pulses are registered on the same edge as the count.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module ttc_counter
  import ttc_cnt_pkg::*;
(
  input  wire logic      pclk7,
  input  wire logic      n_p_reset7,
  input  wire ttc_ctrl_t ctrl,
  input  wire ttc_cmp_t  cmp,
  input  wire logic      restart,       // Zeroes count on this edge
  output ttc_count_t     count,
  output ttc_events_t    events
);

  ttc_count_t  count_q;
  ttc_events_t events_q;
  logic        at_interval;             // Count sits on the interval value
  logic        at_max;                  // Count sits on 0xFFFF
  logic [2:0]  match_hit;               // [2] match3 .. [0] match1
  logic        match_on;

  assign at_interval = (count_q == cmp.interval);
  assign at_max      = (count_q == cnt_max);

  // Compare all three at once
  assign match_hit = {count_q == cmp.match3,
                      count_q == cmp.match2,
                      count_q == cmp.match1};

  assign match_on = ctrl.match_en & ctrl.enable;

  //--------------------
  // Count and wrap
  //--------------------
  always_ff @(posedge pclk7 or negedge n_p_reset7)
  begin
    if (!n_p_reset7)
    begin
      count_q  <= '0;
      events_q <= '0;
    end
    else
    begin
      events_q.interval <= 1'b0;        // Pulses by default
      events_q.overflow <= 1'b0;

      if (restart)
        count_q <= '0;                  // Wins over enable, no wrap event
      else if (ctrl.enable)
      begin
        if (ctrl.interval_mode && at_interval)
        begin
          count_q           <= '0;
          events_q.interval <= 1'b1;
        end
        else if (!ctrl.interval_mode && at_max)
        begin
          count_q           <= '0;
          events_q.overflow <= 1'b1;
        end
        else
          count_q <= count_q + ttc_count_t'(1);  // Plain wraps past 0xFFFF silently
      end

      // Match pulses follow the count seen at this edge
      events_q.match <= match_on ? match_hit : 3'b000;
    end
  end

  assign count  = count_q;
  assign events = events_q;

endmodule

`default_nettype wire

//--- verilog/ttc_interrupt.sv
//--------------------
// Interrupt block of the timer
// Captures rising edges of the counter events, sets masked sticky
// status bits and ORs them onto the interrupt line. Reading the
// status clears it unless a fresh edge came in the cycle before.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module ttc_interrupt
  import ttc_reg_pkg::*;
  import ttc_cnt_pkg::*;
(
  input  wire logic           pclk7,
  input  wire logic           n_p_reset7,
  input  wire ttc_events_t    events,
  input  wire ttc_intr_bits_t wdata_en,        // New enable value
  input  wire logic           intr_en_sel,     // Write strobe for enable
  input  wire logic           clear_interrupt, // Read of the status
  output ttc_intr_bits_t      intr_reg,
  output ttc_intr_bits_t      intr_en,
  output logic                interrupt
);

  ttc_intr_bits_t    detect;            // Events in register layout
  logic [intr_w-1:0] sync_q;            // Events one cycle late
  logic [intr_w-1:0] edge_q;            // Rising edges, one cycle wide
  logic [intr_w-1:0] status_q;
  logic [intr_w-1:0] enable_q;
  logic              edge_seen_q;       // Edge captured last cycle
  logic [intr_w-1:0] new_bits;

  // Map pulses into the register view
  always_comb
  begin
    detect          = '0;               // Spare stays zero
    detect.overflow = events.overflow;
    detect.match3   = events.match[2];
    detect.match2   = events.match[1];
    detect.match1   = events.match[0];
    detect.interval = events.interval;
  end

  assign new_bits = edge_q & enable_q;  // Masked captures

  //--------------------
  // Capture and sticky status
  //--------------------
  always_ff @(posedge pclk7 or negedge n_p_reset7)
  begin
    if (!n_p_reset7)
    begin
      sync_q      <= '0;
      edge_q      <= '0;
      status_q    <= '0;
      enable_q    <= '0;
      edge_seen_q <= 1'b0;
    end
    else
    begin
      sync_q      <= detect;
      edge_q      <= ~sync_q & detect;
      edge_seen_q <= |edge_q;
      if (clear_interrupt && !edge_seen_q)
        status_q <= new_bits;           // Keep only fresh captures
      else
        status_q <= status_q | new_bits;
      if (intr_en_sel)
        enable_q <= wdata_en;
    end
  end

  assign intr_reg  = status_q;
  assign intr_en   = enable_q;
  assign interrupt = |status_q;

endmodule

`default_nettype wire

//--- verilog/ttc_timer_top.sv
//--------------------
// Top level of the triple-compare timer
// APB slave with one 16-bit counter and a single interrupt line.
// Connects the register file, the counter and the interrupt block.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module ttc_timer_top
  import ttc_reg_pkg::*;
  import ttc_cnt_pkg::*;
(
  input  wire logic              pclk7,
  input  wire logic              n_p_reset7,
  input  wire logic              psel,
  input  wire logic              penable,
  input  wire logic              pwrite,
  input  wire logic [addr_w-1:0] paddr,
  input  wire logic [data_w-1:0] pwdata,
  output logic      [data_w-1:0] prdata,
  output logic                   interrupt
);

  ttc_ctrl_t      ctrl;
  ttc_cmp_t       cmp;
  ttc_count_t     count;
  ttc_events_t    events;
  ttc_intr_bits_t intr_reg;
  ttc_intr_bits_t intr_en;
  ttc_intr_bits_t wdata_en;
  logic           restart;
  logic           intr_en_sel;
  logic           clear_interrupt;

  // Bus side
  ttc_apb_regs ttc_apb_regs_inst (
    .pclk7           (pclk7),
    .n_p_reset7      (n_p_reset7),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .count           (count),
    .intr_reg        (intr_reg),
    .intr_en         (intr_en),
    .prdata          (prdata),
    .ctrl            (ctrl),
    .cmp             (cmp),
    .restart         (restart),
    .intr_en_sel     (intr_en_sel),
    .clear_interrupt (clear_interrupt),
    .wdata_en        (wdata_en)
  );

  ttc_counter ttc_counter_inst (
    .pclk7      (pclk7),
    .n_p_reset7 (n_p_reset7),
    .ctrl       (ctrl),
    .cmp        (cmp),
    .restart    (restart),
    .count      (count),
    .events     (events)
  );

  // Events to the interrupt line
  ttc_interrupt ttc_interrupt_inst (
    .pclk7           (pclk7),
    .n_p_reset7      (n_p_reset7),
    .events          (events),
    .wdata_en        (wdata_en),
    .intr_en_sel     (intr_en_sel),
    .clear_interrupt (clear_interrupt),
    .intr_reg        (intr_reg),
    .intr_en         (intr_en),
    .interrupt       (interrupt)
  );

endmodule

`default_nettype wire

//--- tb/ttc_tb.sv
//--------------------
// Testbench of the triple-compare timer
// Drives APB accesses on the falling edge, keeps a cycle model of the
// registers, counter and interrupt block, and checks every read and
// the interrupt line against it. Random trials use a fixed seed.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module ttc_tb
  import ttc_reg_pkg::*;
  import ttc_cnt_pkg::*;
;
  localparam int n_trials    = 40;
  localparam int cycle_limit = 70000 + 200 * n_trials;  // Free-run pass plus trials

  logic pclk7, n_p_reset7, psel, penable, pwrite, interrupt;
  logic [addr_w-1:0] paddr;
  logic [data_w-1:0] pwdata, prdata;
  integer seed = 79;
  int cycles = 0;
  logic line_check_on = 1'b0;

  // Model state
  ttc_ctrl_t m_ctrl;
  ttc_cmp_t m_cmp;
  logic m_restart, m_seen;
  ttc_count_t m_count;
  ttc_events_t m_ev;
  logic [intr_w-1:0] m_sync, m_edge;
  ttc_intr_bits_t m_status, m_en;

  ttc_timer_top ttc_timer_top_inst (
    .pclk7(pclk7), .n_p_reset7(n_p_reset7), .psel(psel), .penable(penable),
    .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
    .interrupt(interrupt)
  );

  initial
  begin
    pclk7 = 1'b0;
    forever #5 pclk7 = ~pclk7;
  end

  //--------------------
  // Failure reporting
  //--------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_count(input string name, input ttc_count_t got, input ttc_count_t exp);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_intr(input string name, input ttc_intr_bits_t got,
                            input ttc_intr_bits_t exp);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_data(input string name, input logic [data_w-1:0] got,
                            input logic [data_w-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_line(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
  endtask

  // Cycle limit
  always @(posedge pclk7)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
      abort_run($sformatf("Timeout: the run went past %0d cycles", cycle_limit));
  end

  //--------------------
  // Cycle model
  //--------------------
  always @(posedge pclk7 or negedge n_p_reset7)
  begin : model_step
    ttc_events_t ev_n;
    ttc_intr_bits_t det;
    logic [intr_w-1:0] fresh;
    logic wr, rd;
    wr = psel && penable && pwrite;
    rd = psel && penable && !pwrite;
    if (!n_p_reset7)
    begin
      m_ctrl    <= '0;
      m_cmp     <= '0;
      m_restart <= 1'b0;
      m_count   <= '0;
      m_ev      <= '0;
      m_sync    <= '0;
      m_edge    <= '0;
      m_seen    <= 1'b0;
      m_status  <= '0;
      m_en      <= '0;
    end
    else
    begin
      // Register writes, restart is a write-one pulse
      m_restart <= wr && (paddr == addr_ctrl) && pwdata[3];
      if (wr && paddr == addr_ctrl)     m_ctrl <= ttc_ctrl_t'(pwdata[2:0]);
      if (wr && paddr == addr_interval) m_cmp.interval <= pwdata[15:0];
      if (wr && paddr == addr_match1)   m_cmp.match1 <= pwdata[15:0];
      if (wr && paddr == addr_match2)   m_cmp.match2 <= pwdata[15:0];
      if (wr && paddr == addr_match3)   m_cmp.match3 <= pwdata[15:0];
      if (wr && paddr == addr_intr_en)  m_en <= ttc_intr_bits_t'(pwdata[5:0]);
      // Counter
      ev_n = '0;
      if (m_restart)
        m_count <= '0;
      else if (m_ctrl.enable)
      begin
        if (m_ctrl.interval_mode && m_count == m_cmp.interval)
        begin
          m_count <= '0;
          ev_n.interval = 1'b1;
        end
        else if (!m_ctrl.interval_mode && m_count == 16'hFFFF)
        begin
          m_count <= '0;
          ev_n.overflow = 1'b1;
        end
        else
          m_count <= m_count + 16'd1;
      end
      if (m_ctrl.match_en && m_ctrl.enable)
        ev_n.match = {m_count == m_cmp.match3, m_count == m_cmp.match2,
                      m_count == m_cmp.match1};
      m_ev <= ev_n;
      // Interrupt block, edge then sticky
      det = '0;
      det.overflow = m_ev.overflow;
      det.match3 = m_ev.match[2];
      det.match2 = m_ev.match[1];
      det.match1 = m_ev.match[0];
      det.interval = m_ev.interval;
      fresh = m_edge & m_en;
      m_sync <= det;
      m_edge <= ~m_sync & det;
      m_seen <= |m_edge;
      if (rd && paddr == addr_intr && !m_seen)
        m_status <= fresh;              // Clear keeps new captures only
      else
        m_status <= m_status | fresh;
    end
  end

  // Expected read data from the register map
  function automatic logic [data_w-1:0] expected_read(input logic [addr_w-1:0] a);
    logic [data_w-1:0] v;
    v = '0;
    case (a)
      addr_ctrl:     v[2:0] = m_ctrl;
      addr_interval: v[15:0] = m_cmp.interval;
      addr_match1:   v[15:0] = m_cmp.match1;
      addr_match2:   v[15:0] = m_cmp.match2;
      addr_match3:   v[15:0] = m_cmp.match3;
      addr_count:    v[15:0] = m_count;
      addr_intr:     v[5:0] = m_status;
      addr_intr_en:  v[5:0] = m_en;
      default:       v = '0;            // Undecoded
    endcase
    return v;
  endfunction

  // Interrupt level against the model, every cycle
  always @(negedge pclk7)
  begin
    if (line_check_on)
      check_line("interrupt", interrupt, |m_status);
  end

  //--------------------
  // APB access tasks
  //--------------------
  task automatic apb_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    @(negedge pclk7);
    psel    = 1'b1;                     // Setup
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = a;
    pwdata  = d;
    @(negedge pclk7);
    penable = 1'b1;                     // Access
    @(negedge pclk7);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [addr_w-1:0] a, output logic [data_w-1:0] rd,
                          output logic [data_w-1:0] ex);
    @(negedge pclk7);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = a;
    @(negedge pclk7);
    penable = 1'b1;
    #1;
    rd = prdata;                        // Settled access phase data
    ex = expected_read(a);
    @(negedge pclk7);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  //--------------------
  // Test sequence
  //--------------------
  initial
  begin : run_tests
    logic [data_w-1:0] rd, ex;
    integer ivl, mask, k;
    logic me;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    n_p_reset7 = 1'b0;
    repeat (2) @(posedge pclk7);
    @(negedge pclk7);
    n_p_reset7 = 1'b1;
    line_check_on = 1'b1;

    // Register readback and undecoded holes
    apb_write(addr_ctrl, 32'h0000_0006);      // Mode bits only, counter stays off
    apb_write(addr_interval, 32'h0000_1234);
    apb_write(addr_match1, 32'h0000_0011);
    apb_write(addr_match2, 32'h0000_0022);
    apb_write(addr_match3, 32'h0000_0033);
    apb_write(addr_intr_en, 32'hFFFF_FFC5);   // Only the low 6 bits stick
    apb_read(addr_ctrl, rd, ex);
    check_data("ctrl", rd, ex);
    apb_read(addr_interval, rd, ex);
    check_data("interval", rd, ex);
    apb_read(addr_match1, rd, ex);
    check_data("match1", rd, ex);
    apb_read(addr_match2, rd, ex);
    check_data("match2", rd, ex);
    apb_read(addr_match3, rd, ex);
    check_data("match3", rd, ex);
    apb_read(addr_intr_en, rd, ex);
    check_data("intr_en", rd, ex);
    apb_read(8'h20, rd, ex);
    check_data("undecoded 0x20", rd, 32'h0);
    apb_read(8'hFC, rd, ex);
    check_data("undecoded 0xFC", rd, 32'h0);

    // Interval mode count and restart
    apb_write(addr_interval, 32'd20);
    apb_write(addr_ctrl, 32'h0000_000B);      // Restart, interval mode, enable
    for (k = 0; k < 30; k++)
    begin
      apb_read(addr_count, rd, ex);
      check_count("count", rd[15:0], ex[15:0]);
    end
    apb_write(addr_ctrl, 32'h0000_000B);
    apb_read(addr_count, rd, ex);
    check_count("count after restart", rd[15:0], ex[15:0]);

    // Interval interrupt and clear on read, from a clean status
    apb_write(addr_ctrl, 32'h0000_0000);      // Stop, let events drain
    apb_write(addr_intr_en, 32'h0000_0001);
    apb_write(addr_interval, 32'd10);
    apb_read(addr_intr, rd, ex);
    check_intr("intr_reg before interval", rd[5:0], ex[5:0]);
    check_line("interrupt before interval", interrupt, 1'b0);
    apb_write(addr_ctrl, 32'h0000_000B);
    while (!m_status.interval)
      @(negedge pclk7);
    check_line("interrupt on interval", interrupt, 1'b1);
    apb_read(addr_intr, rd, ex);
    check_intr("intr_reg", rd[5:0], ex[5:0]);
    @(negedge pclk7);
    check_line("interrupt after read", interrupt, 1'b0);  // Next wrap is far off

    // Random match trials
    for (int t = 0; t < n_trials; t++)
    begin
      ivl = 8 + ({$random(seed)} % 56);
      mask = {$random(seed)} % 64;
      me = ($random(seed) & 1) != 0;
      apb_write(addr_ctrl, 32'h0);
      apb_write(addr_interval, ivl);
      apb_write(addr_match1, {$random(seed)} % ivl);
      apb_write(addr_match2, {$random(seed)} % ivl);
      apb_write(addr_match3, {$random(seed)} % ivl);
      apb_write(addr_intr_en, mask);
      apb_read(addr_intr, rd, ex);
      check_intr("intr_reg before trial", rd[5:0], ex[5:0]);
      apb_write(addr_ctrl, {28'd0, 1'b1, me, 2'b11});
      for (k = 0; k <= ivl / 2; k++)
      begin
        apb_read(addr_count, rd, ex);
        check_count("count", rd[15:0], ex[15:0]);
      end
      apb_read(addr_intr, rd, ex);
      check_intr("intr_reg after trial", rd[5:0], ex[5:0]);
    end

    // Free-run overflow
    apb_write(addr_ctrl, 32'h0);
    apb_write(addr_intr_en, 32'h0000_0030);   // Overflow and the spare bit
    apb_read(addr_intr, rd, ex);
    check_intr("intr_reg before free-run", rd[5:0], ex[5:0]);
    apb_write(addr_ctrl, 32'h0000_0009);      // Restart, free-run, enable
    while (!m_status.overflow)
      @(negedge pclk7);
    apb_read(addr_intr, rd, ex);
    check_intr("intr_reg overflow", rd[5:0], ex[5:0]);
    check_line("spare bit", rd[5], 1'b0);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/ttc_reg_pkg.sv
verilog/ttc_cnt_pkg.sv
verilog/ttc_apb_regs.sv
verilog/ttc_counter.sv
verilog/ttc_interrupt.sv
verilog/ttc_timer_top.sv
tb/ttc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the timer testbench with Verilator and run it.
# The exit status is the simulator's own.
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/1ps -f sim.f --top-module ttc_tb -o ttc_sim \
  && ./obj_dir/ttc_sim \
  || { echo "simulation failed"; exit 1; }
